/* src/avalonPkg.sv */
`default_nettype none

package avalonPkg;

    // ------------------------------------------------------------------------
    // bus geometry
    // ------------------------------------------------------------------------

    parameter int AddrWidth   = 30;                 // word address without byte offset.
    parameter int DataWidth   = 32;                 // one data word.
    parameter int ByteEnWidth = DataWidth / 8;      // one enable per byte lane.

    // ------------------------------------------------------------------------
    // fixed words
    // ------------------------------------------------------------------------

    // returned by any read that lands outside every peripheral.
    parameter logic [DataWidth-1:0] UnmappedReadValue = 32'hDEADBEEF;

    parameter logic [DataWidth-1:0] RegResetValue = 32'h00000005;  // power-on register value.

endpackage

`default_nettype wire

/* src/avalonRegSlave.sv */
`timescale 1ns/1ps
`default_nettype none

module avalonRegSlave
    import avalonPkg::*;
#(
    parameter int NumRegs         = 4,
    parameter int WriteWaitCycles = 0,
    parameter int ReadWaitCycles  = 0
) (
    input  logic                   i_Clk,
    input  logic                   i_rstN,
    input  logic [AddrWidth-1:0]   i_RegAddr,
    input  logic [ByteEnWidth-1:0] i_ByteEn,
    input  logic                   i_Read,
    input  logic                   i_Write,
    input  logic [DataWidth-1:0]   i_WriteData,
    output logic [DataWidth-1:0]   o_ReadData,
    output logic                   o_WaitRequest
);

    localparam int IdxWidth = (NumRegs > 1) ? $clog2(NumRegs) : 1;

    localparam logic [3:0] WrWait = 4'(WriteWaitCycles);  // wait counts fit in 4 bits.
    localparam logic [3:0] RdWait = 4'(ReadWaitCycles);

    logic [DataWidth-1:0] r_Regs [NumRegs];

    logic [3:0]          r_WrCnt;
    logic [3:0]          r_RdCnt;
    logic                w_WrDone;
    logic                w_RdDone;
    logic                w_WrAccept;
    logic                w_RdAccept;
    logic                w_InRange;
    logic [IdxWidth-1:0] w_RegIdx;

    assign w_InRange = (i_RegAddr < AddrWidth'(NumRegs));
    assign w_RegIdx  = i_RegAddr[IdxWidth-1:0];          // only valid when in range.

    // ------------------------------------------------------------------------
    // wait-state handling
    // ------------------------------------------------------------------------

    assign w_WrDone = (r_WrCnt == WrWait);
    assign w_RdDone = (r_RdCnt == RdWait);

    assign o_WaitRequest = (i_Write && !w_WrDone) || (i_Read && !w_RdDone);

    assign w_WrAccept = i_Write && !o_WaitRequest;
    assign w_RdAccept = i_Read && !o_WaitRequest;

    // counters run while their request is held and restart after acceptance.
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            r_WrCnt <= '0;
            r_RdCnt <= '0;
        end else begin
            if (i_Write && !w_WrDone) begin
                r_WrCnt <= r_WrCnt + 4'd1;
            end else begin
                r_WrCnt <= '0;                           // idle or accepted.
            end

            if (i_Read && !w_RdDone) begin
                r_RdCnt <= r_RdCnt + 4'd1;
            end else begin
                r_RdCnt <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // register bank
    // ------------------------------------------------------------------------

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                r_Regs[i] <= RegResetValue;
            end
        end else if (w_WrAccept && w_InRange) begin
            // merge enabled lanes, leave the others as they were.
            for (int b = 0; b < ByteEnWidth; b++) begin
                if (i_ByteEn[b]) begin
                    r_Regs[w_RegIdx][b*8 +: 8] <= i_WriteData[b*8 +: 8];
                end
            end
        end
    end

    // read data is present for exactly one cycle after acceptance.
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_ReadData <= '0;
        end else if (w_RdAccept && w_InRange) begin
            o_ReadData <= r_Regs[w_RegIdx];
        end else begin
            o_ReadData <= '0;                            // out of range reads give zero.
        end
    end

endmodule

`default_nettype wire

/* src/avalonFabric.sv */
`timescale 1ns/1ps
`default_nettype none

module avalonFabric
    import avalonPkg::*;
#(
    parameter int NumSelBits = 2,
    parameter int NumSlaves  = 3
) (
    input  logic                           i_Clk,
    input  logic                           i_rstN,
    input  logic [AddrWidth-1:0]           i_AV_Addr,
    input  logic                           i_AV_Read,
    input  logic                           i_AV_Write,
    output logic                           o_AV_WaitRequest,
    output logic [DataWidth-1:0]           o_AV_ReadData,
    output logic                           o_AV_ReadDataValid,
    output logic [NumSlaves-1:0]           o_SlvRead,
    output logic [NumSlaves-1:0]           o_SlvWrite,
    input  logic [NumSlaves-1:0]           i_SlvWaitRequest,
    input  logic [NumSlaves*DataWidth-1:0] i_SlvReadData
);

    logic [NumSelBits-1:0] w_Sel;
    logic                  w_Mapped;
    logic                  w_RdAccept;

    logic [NumSelBits-1:0] r_RdSel;
    logic                  r_RdUnmapped;
    logic                  r_RdValid;

    // ------------------------------------------------------------------------
    // request side
    // ------------------------------------------------------------------------

    assign w_Sel    = i_AV_Addr[AddrWidth-1 -: NumSelBits];  // top bits pick the peripheral.
    assign w_Mapped = (int'(w_Sel) < NumSlaves);

    for (genvar k = 0; k < NumSlaves; k++) begin : gateGen
        assign o_SlvRead[k]  = i_AV_Read && w_Mapped && (w_Sel == NumSelBits'(k));
        assign o_SlvWrite[k] = i_AV_Write && w_Mapped && (w_Sel == NumSelBits'(k));
    end

    // unmapped requests never wait.
    assign o_AV_WaitRequest = w_Mapped ? i_SlvWaitRequest[w_Sel] : 1'b0;

    assign w_RdAccept = i_AV_Read && !o_AV_WaitRequest;

    // ------------------------------------------------------------------------
    // read return
    // ------------------------------------------------------------------------

    // remember where the accepted read went, so the data can be picked next cycle.
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            r_RdValid    <= 1'b0;
            r_RdSel      <= '0;
            r_RdUnmapped <= 1'b0;
        end else begin
            r_RdValid <= w_RdAccept;
            if (w_RdAccept) begin
                r_RdSel      <= w_Sel;
                r_RdUnmapped <= !w_Mapped;
            end
        end
    end

    assign o_AV_ReadDataValid = r_RdValid;

    always_comb begin
        if (!r_RdValid) begin
            o_AV_ReadData = '0;
        end else if (r_RdUnmapped) begin
            o_AV_ReadData = UnmappedReadValue;
        end else begin
            o_AV_ReadData = i_SlvReadData[r_RdSel*DataWidth +: DataWidth];
        end
    end

endmodule

`default_nettype wire

/* src/avalonSoc.sv */
`timescale 1ns/1ps
`default_nettype none

module avalonSoc
    import avalonPkg::*;
#(
    parameter int                       NumSelBits      = 2,
    parameter int                       NumSlaves       = 3,
    parameter int                       NumRegs         = 4,
    parameter logic [4*NumSlaves-1:0]   WriteWaitCycles = {4'd3, 4'd1, 4'd0},
    parameter logic [4*NumSlaves-1:0]   ReadWaitCycles  = {4'd1, 4'd2, 4'd0}
) (
    input  logic                   i_Clk,
    input  logic                   i_rstN,
    input  logic [AddrWidth-1:0]   i_AV_Addr,
    input  logic [ByteEnWidth-1:0] i_AV_ByteEn,
    input  logic                   i_AV_Read,
    input  logic                   i_AV_Write,
    input  logic [DataWidth-1:0]   i_AV_WriteData,
    output logic                   o_AV_WaitRequest,
    output logic [DataWidth-1:0]   o_AV_ReadData,
    output logic                   o_AV_ReadDataValid
);

    logic [NumSlaves-1:0]           w_SlvRead;
    logic [NumSlaves-1:0]           w_SlvWrite;
    logic [NumSlaves-1:0]           w_SlvWaitRequest;
    logic [NumSlaves*DataWidth-1:0] w_SlvReadData;      // peripheral k at slice k.

    // ------------------------------------------------------------------------
    // decode and return path
    // ------------------------------------------------------------------------

    avalonFabric #(
        .NumSelBits (NumSelBits),
        .NumSlaves  (NumSlaves)
    ) fabric_i (
        .i_Clk              (i_Clk),
        .i_rstN             (i_rstN),
        .i_AV_Addr          (i_AV_Addr),
        .i_AV_Read          (i_AV_Read),
        .i_AV_Write         (i_AV_Write),
        .o_AV_WaitRequest   (o_AV_WaitRequest),
        .o_AV_ReadData      (o_AV_ReadData),
        .o_AV_ReadDataValid (o_AV_ReadDataValid),
        .o_SlvRead          (w_SlvRead),
        .o_SlvWrite         (w_SlvWrite),
        .i_SlvWaitRequest   (w_SlvWaitRequest),
        .i_SlvReadData      (w_SlvReadData)
    );

    // ------------------------------------------------------------------------
    // register peripherals
    // ------------------------------------------------------------------------

    for (genvar k = 0; k < NumSlaves; k++) begin : slaveGen
        avalonRegSlave #(
            .NumRegs         (NumRegs),
            .WriteWaitCycles (int'(WriteWaitCycles[k*4 +: 4])),
            .ReadWaitCycles  (int'(ReadWaitCycles[k*4 +: 4]))
        ) slave_i (
            .i_Clk         (i_Clk),
            .i_rstN        (i_rstN),
            .i_RegAddr     ({{NumSelBits{1'b0}}, i_AV_Addr[AddrWidth-NumSelBits-1:0]}),
            .i_ByteEn      (i_AV_ByteEn),
            .i_Read        (w_SlvRead[k]),
            .i_Write       (w_SlvWrite[k]),
            .i_WriteData   (i_AV_WriteData),
            .o_ReadData    (w_SlvReadData[k*DataWidth +: DataWidth]),
            .o_WaitRequest (w_SlvWaitRequest[k])
        );
    end

endmodule

`default_nettype wire

/* test/avalonSocTb.sv */
`timescale 1ns/1ps
`default_nettype none

module avalonSocTb
    import avalonPkg::*;
();

    localparam int  MaxWait   = 3;                  // largest default wait count.
    localparam time ClkPeriod = 10;

    logic                   clk;
    logic                   rstN;
    logic [AddrWidth-1:0]   avAddr;
    logic [ByteEnWidth-1:0] avByteEn;
    logic                   avRead;
    logic                   avWrite;
    logic [DataWidth-1:0]   avWriteData;
    logic                   avWaitRequest;
    logic [DataWidth-1:0]   avReadData;
    logic                   avReadDataValid;

    logic [7:0]             vecOp   [$];
    logic [AddrWidth-1:0]   vecAddr [$];
    logic [ByteEnWidth-1:0] vecBe   [$];
    logic [DataWidth-1:0]   vecWd   [$];
    logic [DataWidth-1:0]   vecExp  [$];
    int                     testErrs[$];

    logic                 loaded      = 1'b0;
    logic                 pendingRead = 1'b0;
    int                   pendingIdx  = 0;
    logic [DataWidth-1:0] pendingExp  = '0;
    int                   passCount   = 0;
    int                   failCount   = 0;
    int                   otherErrs   = 0;
    logic [31:0]          lfsrState   = 32'h077271d1;

    avalonSoc dut_i (
        .i_Clk              (clk),
        .i_rstN             (rstN),
        .i_AV_Addr          (avAddr),
        .i_AV_ByteEn        (avByteEn),
        .i_AV_Read          (avRead),
        .i_AV_Write         (avWrite),
        .i_AV_WriteData     (avWriteData),
        .o_AV_WaitRequest   (avWaitRequest),
        .o_AV_ReadData      (avReadData),
        .o_AV_ReadDataValid (avReadDataValid)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    // shifts left with taps from x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int expectedWait(input logic isWrite, input logic [AddrWidth-1:0] addr);
        logic [1:0] sel;
        sel = addr[AddrWidth-1 -: 2];
        case (sel)
            2'd0:    return 0;
            2'd1:    return isWrite ? 1 : 2;
            2'd2:    return isWrite ? 3 : 1;
            default: return 0;                      // unmapped select never waits.
        endcase
    endfunction

    task automatic loadVectors();
        int                     fd;
        int                     n;
        string                  line;
        logic [7:0]             op;
        logic [AddrWidth-1:0]   addr;
        logic [ByteEnWidth-1:0] be;
        logic [DataWidth-1:0]   wd;
        logic [DataWidth-1:0]   ex;
        fd = $fopen("test/avalonSocVectors.txt", "r");
        if (fd == 0) begin
            $display("could not open test/avalonSocVectors.txt");
            otherErrs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h", op, addr, be, wd, ex);
                if (n == 5 && (op == "W" || op == "R" || op == "B")) begin
                    vecOp.push_back(op);
                    vecAddr.push_back(addr);
                    vecBe.push_back(be);
                    vecWd.push_back(wd);
                    vecExp.push_back(ex);
                    testErrs.push_back(0);
                end else if (n == 5) begin
                    $display("unknown operation in vectors file: %s", line);
                    otherErrs++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic reportTest(input int idx);
        if (testErrs[idx] == 0) begin
            passCount++;
            $display("test %0d %c addr 0x%h: ok", idx, vecOp[idx], vecAddr[idx]);
        end else begin
            failCount++;
            $display("test %0d %c addr 0x%h: fail", idx, vecOp[idx], vecAddr[idx]);
        end
    endtask

    // called right after each rising edge to check the data of the previous acceptance.
    task automatic checkReturn();
        if (pendingRead) begin
            assert (avReadDataValid === 1'b1) else begin
                $display("[ERROR] test %0d: o_AV_ReadDataValid expected 0x1, got 0x%h",
                         pendingIdx, avReadDataValid);
                testErrs[pendingIdx] = testErrs[pendingIdx] + 1;
            end
            assert (avReadData === pendingExp) else begin
                $display("[ERROR] test %0d: o_AV_ReadData expected 0x%h, got 0x%h",
                         pendingIdx, pendingExp, avReadData);
                testErrs[pendingIdx] = testErrs[pendingIdx] + 1;
            end
            pendingRead = 1'b0;
            reportTest(pendingIdx);
        end else begin
            assert (avReadDataValid === 1'b0) else begin
                $display("[ERROR] o_AV_ReadDataValid expected 0x0, got 0x%h", avReadDataValid);
                otherErrs++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // host
    // ------------------------------------------------------------------------

    initial begin
        int   idle;
        int   waitCnt;
        int   expWait;
        logic isWrite;
        logic accepted;
        rstN        = 1'b0;
        avAddr      = '0;
        avByteEn    = '0;
        avRead      = 1'b0;
        avWrite     = 1'b0;
        avWriteData = '0;
        loadVectors();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int i = 0; i < vecOp.size(); i++) begin
            lfsrState = lfsrNext(lfsrState);
            idle      = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
            idle      = idle * 2 + lfsrState[0];
            if (vecOp[i] == "B") begin
                idle = 0;                           // back-to-back read.
            end
            repeat (idle) begin
                @(negedge clk);
                avRead  = 1'b0;
                avWrite = 1'b0;
                @(posedge clk);
                checkReturn();
            end

            isWrite = (vecOp[i] == "W");
            @(negedge clk);
            avAddr      = vecAddr[i];
            avByteEn    = vecBe[i];
            avWriteData = vecWd[i];
            avWrite     = isWrite;
            avRead      = !isWrite;
            waitCnt     = 0;
            accepted    = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                checkReturn();
                if (avWaitRequest === 1'b0) begin
                    accepted = 1'b1;
                end else begin
                    waitCnt++;                      // request held stable meanwhile.
                end
            end

            expWait = expectedWait(isWrite, vecAddr[i]);
            assert (waitCnt == expWait) else begin
                $display("[ERROR] test %0d: o_AV_WaitRequest cycles expected 0x%h, got 0x%h",
                         i, expWait, waitCnt);
                testErrs[i] = testErrs[i] + 1;
            end
            if (isWrite) begin
                reportTest(i);
            end else begin
                pendingRead = 1'b1;
                pendingIdx  = i;
                pendingExp  = vecExp[i];
            end
        end

        @(negedge clk);
        avRead  = 1'b0;
        avWrite = 1'b0;
        @(posedge clk);
        checkReturn();

        $display("%0d tests passed, %0d tests failed, %0d other checks failed",
                 passCount, failCount, otherErrs);
        if (failCount == 0 && otherErrs == 0 && vecOp.size() > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------------

    initial begin : watchdog
        time limit;
        wait (loaded);
        limit = 2 * vecOp.size() * (MaxWait + 5) * ClkPeriod;
        #(limit);
        $display("timeout: the host did not finish all transactions within %0t", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/avalonSocVectors.txt */
# op addr byteen wdata expected, all hex. op W write, R read, B read with no idle cycle.
# addr bits 29:28 select the peripheral, 3 is unmapped. expected is unused for writes.
R 00000000 f 00000000 00000005
R 00000001 f 00000000 00000005
R 00000002 f 00000000 00000005
R 00000003 f 00000000 00000005
R 10000000 f 00000000 00000005
R 10000001 f 00000000 00000005
R 10000002 f 00000000 00000005
R 10000003 f 00000000 00000005
R 20000000 f 00000000 00000005
R 20000001 f 00000000 00000005
R 20000002 f 00000000 00000005
R 20000003 f 00000000 00000005
# full writes, then isolation between peripherals
W 00000000 f 11111111 00000000
W 10000000 f 22222222 00000000
W 20000000 f 33333333 00000000
R 00000000 f 00000000 11111111
R 10000000 f 00000000 22222222
R 20000000 f 00000000 33333333
W 10000002 f a5a5a5a5 00000000
R 00000002 f 00000000 00000005
R 20000002 f 00000000 00000005
R 10000002 f 00000000 a5a5a5a5
# partial writes merge byte lanes
W 00000001 1 000000aa 00000000
W 00000001 c 12345678 00000000
R 00000001 f 00000000 123400aa
W 20000003 6 cafebabe 00000000
R 20000003 f 00000000 00feba05
W 10000001 0 ffffffff 00000000
R 10000001 f 00000000 00000005
# unmapped select and register index out of range
R 30000000 f 00000000 deadbeef
R 30000002 f 00000000 deadbeef
W 30000001 f 77777777 00000000
W 00000004 f 99999999 00000000
W 20000007 f 88888888 00000000
R 00000004 f 00000000 00000000
R 20000007 f 00000000 00000000
R 00000000 f 00000000 11111111
R 20000003 f 00000000 00feba05
# back-to-back reads across peripherals
R 00000000 f 00000000 11111111
B 10000000 f 00000000 22222222
B 20000000 f 00000000 33333333
B 30000000 f 00000000 deadbeef
B 00000001 f 00000000 123400aa
B 20000002 f 00000000 00000005
B 10000002 f 00000000 a5a5a5a5

/* files.f */
src/avalonPkg.sv
src/avalonRegSlave.sv
src/avalonFabric.sv
src/avalonSoc.sv
test/avalonSocTb.sv
